// File: include/brs_params.svh
`ifndef BRS_PARAMS_SVH
`define BRS_PARAMS_SVH

// Branch checkpoint stack sizing.

// Number of checkpoints. Also the width of every branch mask and tag.
`define BR_DEPTH 4

// Architectural registers held in the map table.
`define MT_NUM 8

// Physical register tag width.
`define PRF_IDX_W 5

// One map entry holds the ready bit on top of the physical tag.
`define MT_ENT_W (`PRF_IDX_W + 1)

// Free-list head pointer with its wrap bit.
`define FL_PTR_W 6

`endif

// File: design/brs_pkg.sv
package brs_pkg;

	// Branch resolution state from the ROB.
	// Sampled for one cycle only since there is no handshake.
	typedef enum logic [1:0] {
		BR_NONE    = 2'd0,	// Nothing resolves.
		BR_CORRECT = 2'd1,	// Prediction held so the tag is freed.
		BR_WRONG   = 2'd2	// Mispredict that restores from the checkpoint.
	} br_state_e;

endpackage

// File: design/br_mask_ctrl.sv
`timescale 1ns/1ps
`include "brs_params.svh"

module br_mask_ctrl
	import brs_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 br_valid_i,	// Dispatch offers a branch.
	output logic                 br_ready_o,	// A free tag exists.
	input  br_state_e            res_state_i,	// From the ROB.
	input  logic [`BR_DEPTH-1:0] res_tag_i,	// One-hot tag of the resolving branch.
	input  logic [`BR_DEPTH-1:0] res_dep_mask_i,	// Mask that branch was dispatched under.
	output logic [`BR_DEPTH-1:0] br_mask_o,	// Dependency mask of the new branch.
	output logic [`BR_DEPTH-1:0] br_tag_o,	// Tag given to the new branch.
	output logic [`BR_DEPTH-1:0] alloc_o	// Capture strobe to the checkpoint slots.
);

	logic [`BR_DEPTH-1:0] mask_q;	// Live branch mask.
	logic [`BR_DEPTH-1:0] mask_clr;	// Mask after this cycle's correct-clear.
	logic [`BR_DEPTH-1:0] free_tag;	// Lowest zero bit of mask_clr.
	logic                 found;	// Search already hit a free bit.
	logic                 full;
	logic                 wrong;
	logic                 accept;

	assign wrong = (res_state_i == BR_WRONG);

	// A correct branch frees its bit before the search.
	// So a dispatch in the same cycle can take it over.
	always_comb begin
		mask_clr = mask_q;
		if (res_state_i == BR_CORRECT)
			mask_clr = mask_q & ~res_tag_i;
	end

	assign full = &mask_clr;

	// Priority search, low bit first.
	always_comb begin
		free_tag = '0;
		found    = 1'b0;
		for (int i = 0; i < `BR_DEPTH; i++) begin
			if (!found && !mask_clr[i]) begin
				free_tag[i] = 1'b1;
				found       = 1'b1;
			end
		end
	end

	// No dispatch while a mispredict cuts the mask back.
	assign br_ready_o = !rst_i && !full && !wrong;
	assign accept     = br_valid_i && br_ready_o;

	assign alloc_o   = accept ? free_tag : '0;	// One slot captures.
	assign br_tag_o  = alloc_o;
	assign br_mask_o = mask_q;	// Prior mask, new bit not yet set.

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mask_q <= '0;
		end else if (wrong) begin
			mask_q <= res_dep_mask_i;	// Squash it and all younger.
		end else begin
			mask_q <= mask_clr | alloc_o;
		end
	end

	// The ROB only resolves branches that are live.
	a_res_tag_live: assert property (@(posedge clk) disable iff (rst_i)
		(res_state_i != BR_NONE) |-> ($onehot(res_tag_i) && |(res_tag_i & mask_q)))
		else $error("resolved tag not one-hot or not live");

	// A full stack with nothing freed takes no branch.
	a_no_accept_full: assert property (@(posedge clk) disable iff (rst_i)
		(&mask_q && res_state_i != BR_CORRECT) |-> !accept)
		else $error("branch accepted while stack full");

endmodule

// File: design/br_ckpt_entry.sv
`timescale 1ns/1ps
`include "brs_params.svh"

module br_ckpt_entry (
	input  logic                           clk,
	input  logic                           rst_i,
	input  logic                           alloc_i,	// Take a new snapshot.
	input  logic [`MT_NUM*`MT_ENT_W-1:0]   mt_data_i,	// Map table with entry 0 low.
	input  logic [`FL_PTR_W-1:0]           fl_head_i,	// Free-list head.
	input  logic                           cdb_vld_i,	// Bus broadcast valid.
	input  logic [`PRF_IDX_W-1:0]          cdb_tag_i,	// Tag being woken up.
	output logic [`MT_NUM*`MT_ENT_W-1:0]   ckpt_mt_o,	// Stored map table.
	output logic [`FL_PTR_W-1:0]           ckpt_fl_o	// Stored free-list head.
);

	localparam int RDY = `MT_ENT_W - 1;	// Ready bit position.

	logic [`MT_NUM-1:0][`MT_ENT_W-1:0] mt_in;	// Incoming snapshot, split.
	logic [`MT_NUM-1:0][`MT_ENT_W-1:0] mt_src;	// Data the wakeup applies to.
	logic [`MT_NUM-1:0][`MT_ENT_W-1:0] mt_d;	// Next stored data.
	logic [`MT_NUM-1:0][`MT_ENT_W-1:0] mt_q;	// Snapshot storage.
	logic [`MT_NUM-1:0]                wake;	// Per entry tag hit.
	logic [`FL_PTR_W-1:0]              fl_q;

	assign mt_in = mt_data_i;

	// Capture takes the fresh snapshot.
	// The wakeup is merged in either way, so a broadcast in the capture cycle is kept.
	always_comb begin
		mt_src = alloc_i ? mt_in : mt_q;
		for (int i = 0; i < `MT_NUM; i++) begin
			wake[i] = cdb_vld_i && (mt_src[i][`PRF_IDX_W-1:0] == cdb_tag_i);
			mt_d[i] = {mt_src[i][RDY] | wake[i], mt_src[i][`PRF_IDX_W-1:0]};
		end
	end

	// Snapshot and head registers.
	always_ff @(posedge clk) begin
		mt_q <= mt_d;	// Ready bits keep updating while stored.
		if (alloc_i)
			fl_q <= fl_head_i;
	end

	assign ckpt_mt_o = mt_q;
	assign ckpt_fl_o = fl_q;

	// The controller holds off allocation during reset.
	a_no_alloc_rst: assert property (@(posedge clk) rst_i |-> !alloc_i)
		else $error("checkpoint captured during reset");

endmodule

// File: design/br_recover_sel.sv
`timescale 1ns/1ps
`include "brs_params.svh"

module br_recover_sel
	import brs_pkg::*;
(
	input  br_state_e                                res_state_i,
	input  logic [`BR_DEPTH-1:0]                     res_tag_i,	// One-hot.
	input  logic [`BR_DEPTH*`MT_NUM*`MT_ENT_W-1:0]   ckpt_mt_i,	// All slots with slot 0 low.
	input  logic [`BR_DEPTH*`FL_PTR_W-1:0]           ckpt_fl_i,	// All slots with slot 0 low.
	output logic                                     rc_valid_o,	// Recovery this cycle.
	output logic [`MT_NUM*`MT_ENT_W-1:0]             rc_mt_data_o,	// Map table to restore.
	output logic [`FL_PTR_W-1:0]                     rc_fl_head_o	// Free-list head to restore.
);

	localparam int MTW = `MT_NUM * `MT_ENT_W;	// One slot's map data.

	logic                 wrong;
	logic [MTW-1:0]       mt_sel;
	logic [`FL_PTR_W-1:0] fl_sel;

	assign wrong = (res_state_i == BR_WRONG);

	// AND-OR mux over a one-hot tag.
	always_comb begin
		mt_sel = '0;
		fl_sel = '0;
		for (int i = 0; i < `BR_DEPTH; i++) begin
			mt_sel = mt_sel | (ckpt_mt_i[i*MTW +: MTW] & {MTW{res_tag_i[i]}});
			fl_sel = fl_sel | (ckpt_fl_i[i*`FL_PTR_W +: `FL_PTR_W] & {`FL_PTR_W{res_tag_i[i]}});
		end
	end

	assign rc_valid_o   = wrong;
	assign rc_mt_data_o = wrong ? mt_sel : '0;	// Quiet outside a mispredict.
	assign rc_fl_head_o = wrong ? fl_sel : '0;

	// A second set tag would OR two snapshots together.
	always_comb begin
		if (wrong)
			assert ($onehot(res_tag_i)) else $error("mispredict tag not one-hot");
	end

endmodule

// File: design/branch_stack.sv
`timescale 1ns/1ps
`include "brs_params.svh"

module branch_stack
	import brs_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_i,
	// Dispatch.
	input  logic                           br_valid_i,
	output logic                           br_ready_o,
	output logic [`BR_DEPTH-1:0]           br_tag_o,	// One-hot tag of the new branch.
	output logic [`BR_DEPTH-1:0]           br_mask_o,	// Its dependency mask.
	input  logic [`MT_NUM*`MT_ENT_W-1:0]   bak_mt_data_i,	// Map table to save.
	input  logic [`FL_PTR_W-1:0]           bak_fl_head_i,	// Free-list head to save.
	// Resolution from the ROB.
	input  br_state_e                      res_state_i,
	input  logic [`BR_DEPTH-1:0]           res_tag_i,
	input  logic [`BR_DEPTH-1:0]           res_dep_mask_i,
	// Common data bus.
	input  logic                           cdb_vld_i,
	input  logic [`PRF_IDX_W-1:0]          cdb_tag_i,
	// Recovery.
	output logic                           rc_valid_o,
	output logic [`MT_NUM*`MT_ENT_W-1:0]   rc_mt_data_o,
	output logic [`FL_PTR_W-1:0]           rc_fl_head_o
);

	localparam int MTW = `MT_NUM * `MT_ENT_W;

	logic [`BR_DEPTH-1:0]           alloc;	// Capture strobes.
	logic [`BR_DEPTH*MTW-1:0]       ckpt_mt;	// All stored map tables.
	logic [`BR_DEPTH*`FL_PTR_W-1:0] ckpt_fl;	// All stored heads.

	br_mask_ctrl u_mask_ctrl (
		.clk            (clk),
		.rst_i          (rst_i),
		.br_valid_i     (br_valid_i),
		.br_ready_o     (br_ready_o),
		.res_state_i    (res_state_i),
		.res_tag_i      (res_tag_i),
		.res_dep_mask_i (res_dep_mask_i),
		.br_mask_o      (br_mask_o),
		.br_tag_o       (br_tag_o),
		.alloc_o        (alloc)
	);

	// One slot per tag bit.
	for (genvar g = 0; g < `BR_DEPTH; g++) begin : g_ckpt
		br_ckpt_entry u_entry (
			.clk       (clk),
			.rst_i     (rst_i),
			.alloc_i   (alloc[g]),
			.mt_data_i (bak_mt_data_i),
			.fl_head_i (bak_fl_head_i),
			.cdb_vld_i (cdb_vld_i),
			.cdb_tag_i (cdb_tag_i),
			.ckpt_mt_o (ckpt_mt[g*MTW +: MTW]),
			.ckpt_fl_o (ckpt_fl[g*`FL_PTR_W +: `FL_PTR_W])
		);
	end

	br_recover_sel u_recover_sel (
		.res_state_i  (res_state_i),
		.res_tag_i    (res_tag_i),
		.ckpt_mt_i    (ckpt_mt),
		.ckpt_fl_i    (ckpt_fl),
		.rc_valid_o   (rc_valid_o),
		.rc_mt_data_o (rc_mt_data_o),
		.rc_fl_head_o (rc_fl_head_o)
	);

endmodule

// File: bench/branch_stack_tb.sv
`timescale 1ns/1ps
`include "brs_params.svh"

module branch_stack_tb
	import brs_pkg::*;
();

	localparam int MTW     = `MT_NUM * `MT_ENT_W;	// Flattened map table width.
	localparam int RDY     = `MT_ENT_W - 1;	// Ready bit inside one entry.
	localparam int OP_IDLE = 0;
	localparam int OP_DISP = 1;
	localparam int OP_CORR = 2;
	localparam int OP_WRONG = 3;
	localparam int OP_DCORR = 4;	// Dispatch and correct together.
	localparam int N_RAND  = 300;

	// One table row. For a bus row without dispatch, tag picks the stored slot.
	typedef struct packed {
		logic [3:0]           test;
		logic [2:0]           op;
		logic                 bus;
		logic [`BR_DEPTH-1:0] tag;
		logic [`BR_DEPTH-1:0] dep;
		logic [2:0]           btag;	// Map entry whose tag goes on the bus.
		logic [`BR_DEPTH-1:0] emask;
		logic [`BR_DEPTH-1:0] etag;
		logic                 erdy;
		logic                 ercv;
	} row_t;

	logic                  clk;
	logic                  rst_i;
	logic                  br_valid_i;
	logic                  br_ready_o;
	logic [`BR_DEPTH-1:0]  br_tag_o;
	logic [`BR_DEPTH-1:0]  br_mask_o;
	logic [MTW-1:0]        bak_mt_data_i;
	logic [`FL_PTR_W-1:0]  bak_fl_head_i;
	br_state_e             res_state_i;
	logic [`BR_DEPTH-1:0]  res_tag_i;
	logic [`BR_DEPTH-1:0]  res_dep_mask_i;
	logic                  cdb_vld_i;
	logic [`PRF_IDX_W-1:0] cdb_tag_i;
	logic                  rc_valid_o;
	logic [MTW-1:0]        rc_mt_data_o;
	logic [`FL_PTR_W-1:0]  rc_fl_head_o;

	// Reference model state.
	logic [MTW-1:0]        m_mt [`BR_DEPTH];	// Snapshot per slot.
	logic [`FL_PTR_W-1:0]  m_fl [`BR_DEPTH];
	logic [`BR_DEPTH-1:0]  m_dep [`BR_DEPTH];	// Live older branches per slot.
	logic [`BR_DEPTH-1:0]  m_mask;
	logic [31:0]           rnd;
	int                    err_cnt;
	int                    chk_cnt;
	row_t                  tbl [$];

	branch_stack dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic add_row(input logic [3:0] test, input logic [2:0] op, input logic bus,
			input logic [3:0] tag, input logic [3:0] dep, input logic [2:0] btag,
			input logic [3:0] emask, input logic [3:0] etag, input logic erdy, input logic ercv);
		tbl.push_back({test, op, bus, tag, dep, btag, emask, etag, erdy, ercv});
	endtask

	// Drive one cycle, check against the model at the falling edge, then advance the model.
	task automatic step(input int op, input logic bus, input logic [`BR_DEPTH-1:0] tag,
			input logic [`BR_DEPTH-1:0] dep, input int btag);
		logic [63:0]           r;
		logic [MTW-1:0]        data;
		logic [MTW-1:0]        emt;
		logic [`FL_PTR_W-1:0]  fl;
		logic [`FL_PTR_W-1:0]  efl;
		logic [`BR_DEPTH-1:0]  clr;
		logic [`BR_DEPTH-1:0]  free;
		logic [`BR_DEPTH-1:0]  ntag;
		logic [`PRF_IDX_W-1:0] ctag;
		logic                  disp;
		logic                  corr;
		logic                  wrong;
		logic                  rdy;
		rnd = next_rand(rnd);
		r[63:32] = rnd;
		rnd = next_rand(rnd);
		r[31:0] = rnd;
		data = r[MTW-1:0];
		for (int i = 0; i < `MT_NUM; i++)
			data[i*`MT_ENT_W + RDY] = 1'b0;	// Fresh mappings start not ready.
		fl    = r[MTW +: `FL_PTR_W];
		disp  = (op == OP_DISP) || (op == OP_DCORR);
		corr  = (op == OP_CORR) || (op == OP_DCORR);
		wrong = (op == OP_WRONG);
		ctag  = '0;
		if (bus && disp)
			ctag = data[btag*`MT_ENT_W +: `PRF_IDX_W];	// Tag from the snapshot being saved.
		else if (bus)
			for (int s = 0; s < `BR_DEPTH; s++)
				if (tag[s])
					ctag = m_mt[s][btag*`MT_ENT_W +: `PRF_IDX_W];
		@(posedge clk);
		br_valid_i     <= disp;
		bak_mt_data_i  <= data;
		bak_fl_head_i  <= fl;
		res_state_i    <= wrong ? BR_WRONG : (corr ? BR_CORRECT : BR_NONE);
		res_tag_i      <= (corr || wrong) ? tag : '0;
		res_dep_mask_i <= wrong ? dep : '0;
		cdb_vld_i      <= bus;
		cdb_tag_i      <= ctag;
		@(negedge clk);
		clr  = corr ? (m_mask & ~tag) : m_mask;	// Freed bit is reusable now.
		rdy  = !wrong && (clr != '1);
		free = '0;
		for (int i = `BR_DEPTH - 1; i >= 0; i--)
			if (!clr[i])
				free = `BR_DEPTH'(1) << i;	// Last hit is the lowest free bit.
		ntag = (disp && rdy) ? free : '0;
		emt  = '0;
		efl  = '0;
		for (int s = 0; s < `BR_DEPTH; s++)
			if (wrong && tag[s]) begin
				emt = m_mt[s];
				efl = m_fl[s];
			end
		check("br_ready_o", br_ready_o, rdy);
		check("br_tag_o", br_tag_o, ntag);
		check("br_mask_o", br_mask_o, m_mask);
		check("rc_valid_o", rc_valid_o, wrong);
		check("rc_mt_data_o", rc_mt_data_o, emt);
		check("rc_fl_head_o", rc_fl_head_o, efl);
		for (int s = 0; s < `BR_DEPTH; s++) begin
			if (ntag[s]) begin
				m_mt[s]  = data;
				m_fl[s]  = fl;
				m_dep[s] = clr;
			end
			if (corr)
				m_dep[s] = m_dep[s] & ~tag;	// ROB drops resolved branches from masks.
			for (int i = 0; i < `MT_NUM; i++)
				if (bus && m_mt[s][i*`MT_ENT_W +: `PRF_IDX_W] == ctag)
					m_mt[s][i*`MT_ENT_W + RDY] = 1'b1;
		end
		m_mask = wrong ? dep : (clr | ntag);
	endtask

	task automatic wait_ready(output logic ok);
		ok = 1'b0;
		for (int i = 0; i < 20 && !ok; i++) begin
			@(negedge clk);
			ok = br_ready_o;
		end
	endtask

	initial begin
		row_t                 row;
		logic                 ok;
		logic [`BR_DEPTH-1:0] pick;
		int                   ps;
		int                   op;
		int                   s;
		int                   err_base;
		err_cnt  = 0;
		chk_cnt  = 0;
		err_base = 0;
		rnd      = 32'd97;
		m_mask   = '0;
		for (int k = 0; k < `BR_DEPTH; k++) begin
			m_mt[k]  = '0;
			m_fl[k]  = '0;
			m_dep[k] = '0;
		end
		rst_i          <= 1'b1;
		br_valid_i     <= 1'b0;
		bak_mt_data_i  <= '0;
		bak_fl_head_i  <= '0;
		res_state_i    <= BR_NONE;
		res_tag_i      <= '0;
		res_dep_mask_i <= '0;
		cdb_vld_i      <= 1'b0;
		cdb_tag_i      <= '0;
		add_row(1, OP_IDLE, 0, 4'b0000, 4'b0000, 0, 4'b0000, 4'b0000, 1, 0);	// Quiet after reset.
		add_row(2, OP_DISP, 0, 4'b0000, 4'b0000, 0, 4'b0000, 4'b0001, 1, 0);
		add_row(2, OP_DISP, 0, 4'b0000, 4'b0000, 0, 4'b0001, 4'b0010, 1, 0);
		add_row(2, OP_DISP, 0, 4'b0000, 4'b0000, 0, 4'b0011, 4'b0100, 1, 0);
		add_row(2, OP_DISP, 0, 4'b0000, 4'b0000, 0, 4'b0111, 4'b1000, 1, 0);
		add_row(2, OP_DISP, 0, 4'b0000, 4'b0000, 0, 4'b1111, 4'b0000, 0, 0);	// Held off.
		add_row(2, OP_DISP, 0, 4'b0000, 4'b0000, 0, 4'b1111, 4'b0000, 0, 0);
		add_row(3, OP_CORR, 0, 4'b0010, 4'b0000, 0, 4'b1111, 4'b0000, 1, 0);
		add_row(3, OP_IDLE, 0, 4'b0000, 4'b0000, 0, 4'b1101, 4'b0000, 1, 0);
		add_row(3, OP_DISP, 0, 4'b0000, 4'b0000, 0, 4'b1101, 4'b0010, 1, 0);
		add_row(3, OP_DCORR, 0, 4'b0100, 4'b0000, 0, 4'b1111, 4'b0100, 1, 0);	// Reuse bit 2.
		add_row(4, OP_WRONG, 0, 4'b0010, 4'b1001, 0, 4'b1111, 4'b0000, 0, 1);
		add_row(4, OP_IDLE, 0, 4'b0000, 4'b0000, 0, 4'b1001, 4'b0000, 1, 0);
		add_row(5, OP_IDLE, 1, 4'b0001, 4'b0000, 3, 4'b1001, 4'b0000, 1, 0);	// Wake slot 0.
		add_row(5, OP_DISP, 1, 4'b0000, 4'b0000, 5, 4'b1001, 4'b0010, 1, 0);	// Wake at capture.
		add_row(5, OP_WRONG, 0, 4'b0010, 4'b1001, 0, 4'b1011, 4'b0000, 0, 1);
		add_row(5, OP_WRONG, 0, 4'b0001, 4'b0000, 0, 4'b1001, 4'b0000, 0, 1);
		add_row(5, OP_IDLE, 0, 4'b0000, 4'b0000, 0, 4'b0000, 4'b0000, 1, 0);
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;
		wait_ready(ok);
		if (!ok) begin
			$display("Timeout: br_ready_o did not rise after reset");
			$display("=== FAIL ===");
			$finish;
		end else begin
			for (int k = 0; k < tbl.size(); k++) begin
				row = tbl[k];
				step(row.op, row.bus, row.tag, row.dep, row.btag);
				check("table br_mask_o", br_mask_o, row.emask);
				check("table br_tag_o", br_tag_o, row.etag);
				check("table br_ready_o", br_ready_o, row.erdy);
				check("table rc_valid_o", rc_valid_o, row.ercv);
				if (k == tbl.size() - 1 || tbl[k+1].test != row.test) begin
					$display("test %0d done, %0d errors", row.test, err_cnt - err_base);
					err_base = err_cnt;
				end
			end
			// Random mix; resolutions only target live tags with their true masks.
			for (int n = 0; n < N_RAND; n++) begin
				rnd  = next_rand(rnd);
				pick = '0;
				ps   = 0;
				for (int k = 0; k < `BR_DEPTH; k++) begin
					s = (k + int'(rnd[9:8])) % `BR_DEPTH;
					if (m_mask[s] && pick == '0) begin
						pick = `BR_DEPTH'(1) << s;
						ps   = s;
					end
				end
				if (pick == '0)
					op = rnd[0] ? OP_DISP : OP_IDLE;
				else
					case (rnd[2:0])
						3'd0, 3'd1, 3'd2: op = OP_DISP;
						3'd3: op = OP_CORR;
						3'd4: op = OP_DCORR;
						3'd5: op = OP_WRONG;
						default: op = OP_IDLE;
					endcase
				step(op, rnd[3], pick, m_dep[ps], int'(rnd[6:4]));
			end
			$display("test 6 done, %0d errors", err_cnt - err_base);
			$display("6 tests, %0d checks, %0d errors", chk_cnt, err_cnt);
			if (err_cnt == 0)
				$display("=== PASS ===");
			else
				$display("=== FAIL ===");
			$finish;
		end
	end

endmodule

// File: flist.f
+incdir+include
design/brs_pkg.sv
design/br_mask_ctrl.sv
design/br_ckpt_entry.sv
design/br_recover_sel.sv
design/branch_stack.sv
bench/branch_stack_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch stack testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module branch_stack_tb -o branch_stack_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/branch_stack_sim > sim.log 2>&1 \
	|| echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation passed"
